// File: source/camera_pkg.sv
`default_nettype none

package camera_pkg;

  // chunk geometry
  localparam int PIXELS_PER_CHUNK = 8;
  localparam int PIXEL_W = 16;
  localparam int CHUNK_W = PIXELS_PER_CHUNK * PIXEL_W;

  // colour channel a threshold unit watches
  typedef enum logic [1:0] {
    CH_RED,
    CH_GREEN,
    CH_BLUE
  } channel_e;

  // 8-bit per channel colour
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // inclusive limits for one channel
  typedef struct packed {
    logic [7:0] lower;
    logic [7:0] upper;
  } bounds_t;

  // one camera pixel with its position, data is RGB565
  typedef struct packed {
    logic              valid;
    logic [10:0]       hcount;
    logic [9:0]        vcount;
    logic [PIXEL_W-1:0] data;
  } pixel_t;

  // eight stacked pixels, last marks the end of a frame
  typedef struct packed {
    logic [CHUNK_W-1:0] data;
    logic               last;
  } chunk_t;

  // widen 5:6:5 fields to 8 bits by zero fill on the right
  function automatic rgb_t rgb_from_565(input logic [PIXEL_W-1:0] px);
    rgb_t c;
    c.red = {px[15:11], 3'b000};
    c.green = {px[10:5], 2'b00};
    c.blue = {px[4:0], 3'b000};
    return c;
  endfunction

endpackage

`default_nettype wire

// File: source/pixel_reconstruct.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct
  import camera_pkg::*;
  #(
  parameter int H_PIXELS = 1280,
  parameter int V_LINES = 720
  )
  (
  input wire        clk_camera,
  input wire        recent_reset,
  input wire [7:0]  cam_data_i,
  input wire        cam_pclk_i,
  input wire        cam_hsync_i,
  input wire        cam_vsync_i,
  output pixel_t    pix_o
  );

  // two flop synchronizers, data rides along with pclk
  logic [7:0] data_s1, data_s2;
  logic       pclk_s1, pclk_s2;
  logic       hs_s1, hs_s2;
  logic       vs_s1, vs_s2;

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
    pclk_s1 <= cam_pclk_i;
    pclk_s2 <= pclk_s1;
    hs_s1 <= cam_hsync_i;
    hs_s2 <= hs_s1;
    vs_s1 <= cam_vsync_i;
    vs_s2 <= vs_s1;
  end

  // previous synchronized levels for edge detection
  logic pclk_d, hs_d, vs_d;
  logic pclk_rise, hs_fall, vs_rise;
  // a byte is taken on pclk rise inside the active part of a line
  logic byte_take;

  assign pclk_rise = pclk_s2 && !pclk_d;
  assign hs_fall = !hs_s2 && hs_d;
  assign vs_rise = vs_s2 && !vs_d;
  assign byte_take = pclk_rise && hs_s2;

  // phase 0 waits for the high byte, phase 1 for the low byte
  logic        phase_q;
  logic [10:0] hcount_q;
  logic [9:0]  vcount_q;
  logic        pix_valid_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_d <= 1'b0;
      hs_d <= 1'b0;
      vs_d <= 1'b0;
      phase_q <= 1'b0;
      hcount_q <= '0;
      vcount_q <= '0;
      pix_valid_q <= 1'b0;
    end else begin
      pclk_d <= pclk_s2;
      hs_d <= hs_s2;
      vs_d <= vs_s2;
      // one cycle strobe when the low byte lands
      pix_valid_q <= byte_take && phase_q && !vs_rise;
      if (vs_rise) begin
        // new frame, everything back to origin
        phase_q <= 1'b0;
        hcount_q <= '0;
        vcount_q <= '0;
      end else if (hs_fall) begin
        // end of line
        phase_q <= 1'b0;
        hcount_q <= '0;
        vcount_q <= vcount_q + 1'b1;
      end else if (byte_take) begin
        phase_q <= !phase_q;
        if (phase_q) begin
          hcount_q <= hcount_q + 1'b1;
        end
      end
    end
  end

  // high byte holding and output payload
  logic [7:0]  hi_q;
  logic [15:0] pix_data_q;
  logic [10:0] pix_hcount_q;
  logic [9:0]  pix_vcount_q;

  always_ff @(posedge clk_camera) begin
    if (byte_take && !phase_q) begin
      hi_q <= data_s2;
    end
    if (byte_take && phase_q) begin
      pix_data_q <= {hi_q, data_s2};
      // position of this pixel, before the counter moves on
      pix_hcount_q <= hcount_q;
      pix_vcount_q <= vcount_q;
    end
  end

  assign pix_o.valid = pix_valid_q;
  assign pix_o.hcount = pix_hcount_q;
  assign pix_o.vcount = pix_vcount_q;
  assign pix_o.data = pix_data_q;

  // the camera must never deliver more pixels than the frame geometry allows
  a_pixel_in_frame : assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    pix_o.valid |-> (pix_o.hcount < H_PIXELS) && (pix_o.vcount < V_LINES)
  );

endmodule

`default_nettype wire

// File: source/channel_threshold.sv
`timescale 1ns/1ps
`default_nettype none

module channel_threshold
  import camera_pkg::*;
  #(
  parameter channel_e CHANNEL = CH_RED
  )
  (
  input wire       clk_camera,
  input wire       recent_reset,
  input pixel_t    pix_i,
  input bounds_t   bounds_i,
  output logic     mask_o
  );

  rgb_t       rgb;
  logic [7:0] value;
  logic       in_range;

  // expand to 8 bits and pick the channel this unit watches
  always_comb begin
    rgb = rgb_from_565(pix_i.data);
    case (CHANNEL)
      CH_RED: value = rgb.red;
      CH_GREEN: value = rgb.green;
      default: value = rgb.blue;
    endcase
  end

  // both limits inclusive
  assign in_range = (value >= bounds_i.lower) && (value <= bounds_i.upper);

  // registered so the keyer sees it one cycle after the pixel
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mask_o <= 1'b0;
    end else begin
      mask_o <= in_range;
    end
  end

endmodule

`default_nettype wire

// File: source/chroma_key.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_key
  import camera_pkg::*;
  (
  input wire         clk_camera,
  input wire         recent_reset,
  input pixel_t      pix_i,
  input wire [2:0]   masks_i,
  input wire         key_enable_i,
  input wire [15:0]  key_color_i,
  output pixel_t     keyed_o
  );

  // pixel delayed by one cycle to line up with the registered masks
  logic               valid_q;
  logic [10:0]        hcount_q;
  logic [9:0]         vcount_q;
  logic [PIXEL_W-1:0] data_q;
  // pixel sits inside all three ranges
  logic               key_hit;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pix_i.valid;
    end
  end

  always_ff @(posedge clk_camera) begin
    hcount_q <= pix_i.hcount;
    vcount_q <= pix_i.vcount;
    data_q <= pix_i.data;
  end

  assign key_hit = key_enable_i && (&masks_i);

  // counts and valid pass through, only the colour is swapped
  always_comb begin
    keyed_o.valid = valid_q;
    keyed_o.hcount = hcount_q;
    keyed_o.vcount = vcount_q;
    if (key_hit) begin
      keyed_o.data = key_color_i;
    end else begin
      keyed_o.data = data_q;
    end
  end

endmodule

`default_nettype wire

// File: source/stacker.sv
`timescale 1ns/1ps
`default_nettype none

module stacker
  import camera_pkg::*;
  #(
  parameter int H_PIXELS = 1280,
  parameter int V_LINES = 720
  )
  (
  input wire      clk_camera,
  input wire      recent_reset,
  input pixel_t   pix_i,
  output chunk_t  chunk_o,
  output logic    chunk_valid_o,
  input wire      chunk_ready_i,
  output logic    overflow_o
  );

  localparam int FILL_W = $clog2(PIXELS_PER_CHUNK);

  // assembly side
  logic [FILL_W-1:0]  fill_q;
  logic [FILL_W-1:0]  fill_base;
  logic [CHUNK_W-1:0] asm_q;
  logic [CHUNK_W-1:0] shifted;
  logic               frame_start;
  logic               complete;
  logic               frame_end;
  // output side
  chunk_t             out_q;
  logic               out_valid_q;
  logic               overflow_q;
  logic               out_free;
  logic               load;

  always_comb begin
    // first pixel of a frame throws away any partial chunk
    frame_start = (pix_i.hcount == '0) && (pix_i.vcount == '0);
    fill_base = frame_start ? '0 : fill_q;
    complete = pix_i.valid && (fill_base == FILL_W'(PIXELS_PER_CHUNK - 1));
    frame_end = (pix_i.hcount == 11'(H_PIXELS - 1)) && (pix_i.vcount == 10'(V_LINES - 1));
    // new pixels enter at the top, so pixel 0 ends in the lowest bits
    shifted = {pix_i.data, asm_q[CHUNK_W-1:PIXEL_W]};
    // output slot is empty or being drained this cycle
    out_free = !out_valid_q || chunk_ready_i;
    load = complete && out_free;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      fill_q <= '0;
      out_valid_q <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      if (pix_i.valid) begin
        fill_q <= complete ? '0 : fill_base + 1'b1;
      end
      if (load) begin
        out_valid_q <= 1'b1;
      end else if (chunk_ready_i) begin
        out_valid_q <= 1'b0;
      end
      // chunk finished while the previous one is still held, drop it
      if (complete && !out_free) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pix_i.valid) begin
      asm_q <= shifted;
    end
    if (load) begin
      out_q.data <= shifted;
      out_q.last <= frame_end;
    end
  end

  assign chunk_o = out_q;
  assign chunk_valid_o = out_valid_q;
  assign overflow_o = overflow_q;

  // a held chunk may not change or vanish before the consumer takes it
  a_hold_stable : assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    chunk_valid_o && !chunk_ready_i |=> chunk_valid_o && $stable(chunk_o)
  );

endmodule

`default_nettype wire

// File: source/camera_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module camera_capture_top
  import camera_pkg::*;
  #(
  parameter int H_PIXELS = 1280,
  parameter int V_LINES = 720
  )
  (
  input wire             clk_camera,
  input wire             recent_reset,
  // camera bus, asynchronous
  input wire [7:0]       cam_data_i,
  input wire             cam_pclk_i,
  input wire             cam_hsync_i,
  input wire             cam_vsync_i,
  // static configuration, one bounds entry per channel
  input bounds_t [2:0]   thresholds_i,
  input wire             key_enable_i,
  input wire [15:0]      key_color_i,
  // chunk stream
  output chunk_t         chunk_o,
  output logic           chunk_valid_o,
  input wire             chunk_ready_i,
  output logic           overflow_o
  );

  pixel_t     pix;
  pixel_t     keyed;
  logic [2:0] masks;

  pixel_reconstruct #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) pixel_reconstruct_inst (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .cam_data_i(cam_data_i),
    .cam_pclk_i(cam_pclk_i),
    .cam_hsync_i(cam_hsync_i),
    .cam_vsync_i(cam_vsync_i),
    .pix_o(pix)
  );

  // one range check per colour, mask bit index follows channel_e
  for (genvar ch = 0; ch <= int'(CH_BLUE); ch++) begin : g_threshold
    channel_threshold #(.CHANNEL(channel_e'(ch))) threshold_inst (
      .clk_camera(clk_camera),
      .recent_reset(recent_reset),
      .pix_i(pix),
      .bounds_i(thresholds_i[ch]),
      .mask_o(masks[ch])
    );
  end

  chroma_key chroma_key_inst (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .pix_i(pix),
    .masks_i(masks),
    .key_enable_i(key_enable_i),
    .key_color_i(key_color_i),
    .keyed_o(keyed)
  );

  stacker #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) stacker_inst (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .pix_i(keyed),
    .chunk_o(chunk_o),
    .chunk_valid_o(chunk_valid_o),
    .chunk_ready_i(chunk_ready_i),
    .overflow_o(overflow_o)
  );

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_camera,
  output logic recent_reset
);

  initial begin
    clk_camera = 1'b0;
    forever #(PERIOD_NS / 2) clk_camera = ~clk_camera;
  end

  // held from time zero until the first apply_reset releases it
  initial recent_reset = 1'b1;

  // reset moves on the falling edge like the rest of the stimulus
  task automatic apply_reset();
    @(negedge clk_camera);
    recent_reset = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_camera);
    recent_reset = 1'b0;
  endtask

endmodule

`default_nettype wire

// File: tb/camera_model.svh
`ifndef CAMERA_MODEL_SVH
`define CAMERA_MODEL_SVH

// one byte on the camera bus, data settles while pclk is low
task automatic send_byte(input logic [7:0] b);
  cam_data = b;
  repeat (PCLK_HALF) @(negedge clk_camera);
  cam_pclk = 1'b1;
  repeat (PCLK_HALF) @(negedge clk_camera);
  cam_pclk = 1'b0;
endtask

// true when all three widened channels sit inside their inclusive bounds
function automatic logic in_key_range(input logic [15:0] p);
  logic [7:0] ch [3];
  ch[0] = {p[15:11], 3'b000};
  ch[1] = {p[10:5], 2'b00};
  ch[2] = {p[4:0], 3'b000};
  in_key_range = 1'b1;
  for (int i = 0; i < 3; i++) begin
    if (ch[i] < thresholds[i].lower || ch[i] > thresholds[i].upper) begin
      in_key_range = 1'b0;
    end
  end
endfunction

// keys one pixel and groups pixels by eight into expected chunks
task automatic model_pixel(input logic [15:0] p, input bit frame_last);
  logic [15:0]        k;
  logic [CHUNK_W-1:0] c;
  k = p;
  if (key_enable && in_key_range(p)) begin
    k = key_color;
    key_hits++;
  end
  pending.push_back(k);
  if (pending.size() == PIXELS_PER_CHUNK) begin
    c = '0;
    // pixel 0 of the chunk in the lowest bits
    for (int i = 0; i < PIXELS_PER_CHUNK; i++) begin
      c[i*PIXEL_W +: PIXEL_W] = pending[i];
    end
    // a chunk dropped on overflow never reaches the output
    if (chunk_index != skip_chunk) begin
      exp_data.push_back(c);
      exp_last.push_back(frame_last);
    end
    chunk_index++;
    pending.delete();
  end
endtask

// vsync pulse, then lines of byte pairs, last line may be cut short
task automatic send_frame(input int lines, input int last_len);
  logic [15:0] p;
  int          len;
  // a new frame throws away any partial chunk
  pending.delete();
  chunk_index = 0;
  cam_vsync = 1'b1;
  repeat (8) @(negedge clk_camera);
  cam_vsync = 1'b0;
  repeat (8) @(negedge clk_camera);
  for (int y = 0; y < lines; y++) begin
    len = (y == lines - 1) ? last_len : H_PIX;
    cam_hsync = 1'b1;
    for (int x = 0; x < len; x++) begin
      p = 16'($urandom);
      model_pixel(p, (y == V_LIN - 1) && (x == H_PIX - 1));
      // high byte first
      send_byte(p[15:8]);
      send_byte(p[7:0]);
    end
    cam_hsync = 1'b0;
    repeat (LINE_GAP) @(negedge clk_camera);
  end
endtask

`endif

// File: tb/tb_camera_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_camera_capture
  import camera_pkg::*;
  ();

  localparam int H_PIX = 16;
  localparam int V_LIN = 3;
  localparam int CLK_NS = 8;
  localparam int PCLK_HALF = 4;
  localparam int LINE_GAP = 8;
  // five full frames plus the cut frame of the restart test
  localparam int TOTAL_PIX = 5 * H_PIX * V_LIN + 11;
  localparam int WATCHDOG_NS = TOTAL_PIX * 8 * PCLK_HALF * CLK_NS * 2;

  logic          clk_camera;
  logic          recent_reset;
  logic [7:0]    cam_data;
  logic          cam_pclk;
  logic          cam_hsync;
  logic          cam_vsync;
  bounds_t [2:0] thresholds;
  logic          key_enable;
  logic [15:0]   key_color;
  chunk_t        chunk;
  logic          chunk_valid;
  logic          chunk_ready;
  logic          overflow;

  // reference model state
  logic [15:0]        pending[$];
  logic [CHUNK_W-1:0] exp_data[$];
  bit                 exp_last[$];
  int                 chunk_index;
  int                 skip_chunk = -1;
  int                 key_hits;
  // bookkeeping
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     err_mark;
  int     ov_wait;
  bit     stim_done;
  bit     was_held;
  chunk_t held_chunk;
  logic [CHUNK_W-1:0] e_data;
  bit     e_last;

  clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) clk_gen (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset)
  );

  camera_capture_top #(.H_PIXELS(H_PIX), .V_LINES(V_LIN)) UUT (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .cam_data_i(cam_data),
    .cam_pclk_i(cam_pclk),
    .cam_hsync_i(cam_hsync),
    .cam_vsync_i(cam_vsync),
    .thresholds_i(thresholds),
    .key_enable_i(key_enable),
    .key_color_i(key_color),
    .chunk_o(chunk),
    .chunk_valid_o(chunk_valid),
    .chunk_ready_i(chunk_ready),
    .overflow_o(overflow)
  );

  `include "camera_model.svh"

  // compare the chunk taken in this handshake with the oldest expected one
  task automatic check_chunk();
    if (exp_data.size() == 0) begin
      errors++;
      $display("a chunk arrived at %0t while none was expected", $time);
    end else begin
      e_data = exp_data.pop_front();
      e_last = exp_last.pop_front();
      if (chunk.data !== e_data) begin
        errors++;
        $display("[FAIL] chunk_o.data exp %h got %h", e_data, chunk.data);
      end
      if (chunk.last !== e_last) begin
        errors++;
        $display("[FAIL] chunk_o.last exp %h got %h", e_last, chunk.last);
      end
    end
  endtask

  // flop outputs read at the rising edge are the values of the handshake
  always @(posedge clk_camera) begin
    if (recent_reset) begin
      was_held = 1'b0;
    end else begin
      if (was_held && (chunk_valid !== 1'b1 || chunk !== held_chunk)) begin
        errors++;
        $display("[FAIL] chunk_o held exp %h got %h", held_chunk, chunk);
      end
      if (chunk_valid && chunk_ready) begin
        check_chunk();
      end
      was_held = chunk_valid && !chunk_ready;
      held_chunk = chunk;
    end
  end

  // wait for every expected chunk, then idle a little to catch extras
  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_data.size() > 0 && n < max_cycles) begin
      @(negedge clk_camera);
      n++;
    end
    if (exp_data.size() > 0) begin
      errors++;
      $display("%0d expected chunks never arrived", exp_data.size());
      exp_data.delete();
      exp_last.delete();
    end
    repeat (40) @(negedge clk_camera);
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(73879));
    cam_data = '0;
    cam_pclk = 1'b0;
    cam_hsync = 1'b0;
    cam_vsync = 1'b0;
    thresholds = '0;
    key_enable = 1'b0;
    key_color = '0;
    chunk_ready = 1'b1;
    err_mark = 0;
    clk_gen.apply_reset();

    // outputs quiet after reset and with no pixels
    expect_bit("chunk_valid_o", chunk_valid, 1'b0);
    expect_bit("overflow_o", overflow, 1'b0);
    repeat (40) @(negedge clk_camera);
    expect_bit("chunk_valid_o", chunk_valid, 1'b0);
    end_test("reset");

    send_frame(V_LIN, H_PIX);
    wait_drain(400);
    end_test("packing and byte order");

    // wide random ranges so a good share of pixels hit all three
    for (int i = 0; i < 3; i++) begin
      thresholds[i].lower = 8'($urandom % 64);
      thresholds[i].upper = thresholds[i].lower + 8'd191;
    end
    key_color = 16'($urandom);
    key_enable = 1'b1;
    key_hits = 0;
    send_frame(V_LIN, H_PIX);
    wait_drain(400);
    if (key_hits == 0) begin
      errors++;
      $display("no pixel fell inside the key ranges");
    end
    end_test("chroma key");

    // ready low for less than the 128 cycles a chunk takes to fill
    stim_done = 1'b0;
    fork
      begin
        send_frame(V_LIN, H_PIX);
        stim_done = 1'b1;
      end
      while (!stim_done) begin
        chunk_ready = 1'b0;
        repeat (1 + $urandom % 60) @(negedge clk_camera);
        chunk_ready = 1'b1;
        repeat (1 + $urandom % 20) @(negedge clk_camera);
      end
    join
    chunk_ready = 1'b1;
    wait_drain(400);
    expect_bit("overflow_o", overflow, 1'b0);
    end_test("back-pressure within margin");

    // first chunk is held, second is lost, ready returns before the third
    chunk_ready = 1'b0;
    skip_chunk = 1;
    fork
      send_frame(V_LIN, H_PIX);
      begin
        ov_wait = 0;
        while (overflow !== 1'b1 && ov_wait < 2000) begin
          @(negedge clk_camera);
          ov_wait++;
        end
        if (overflow !== 1'b1) begin
          errors++;
          $display("overflow_o never rose while the output was held");
        end
        chunk_ready = 1'b1;
      end
    join
    wait_drain(400);
    skip_chunk = -1;
    expect_bit("overflow_o", overflow, 1'b1);
    clk_gen.apply_reset();
    expect_bit("overflow_o", overflow, 1'b0);
    expect_bit("chunk_valid_o", chunk_valid, 1'b0);
    end_test("overflow");

    // cut frame leaves three pixels behind, the new frame must drop them
    send_frame(1, 11);
    send_frame(V_LIN, H_PIX);
    wait_drain(400);
    end_test("frame restart");

    $display("%0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/camera_pkg.sv
source/pixel_reconstruct.sv
source/channel_threshold.sv
source/chroma_key.sv
source/stacker.sv
source/camera_capture_top.sv
tb/clock_gen.sv
+incdir+tb
tb/tb_camera_capture.sv
